//--- verilog/ecc87_pkg.sv
package ecc87_pkg;

    localparam int DATA_W  = 87;
    localparam int CHECK_W = 8;
    localparam int POS_W   = 7;   // hamming position width, positions 3..94
    localparam int IDX_W   = 7;   // data bit index width

    typedef logic [DATA_W-1:0]  data_t;
    typedef logic [CHECK_W-1:0] check_t;

    typedef enum logic [1:0] {
        ERR_NONE,
        ERR_SINGLE,
        ERR_DOUBLE
    } err_kind_e;

    // encode -> locate
    typedef struct packed {
        logic   valid;
        logic   bypass;
        data_t  data;
        check_t rx_check;    // check bits as received
        check_t calc_check;  // check bits recomputed from data
    } enc_stage_t;

    // locate -> correct
    typedef struct packed {
        logic             valid;
        data_t            data;
        check_t           calc_check;
        err_kind_e        kind;
        logic             flip;   // data bit at idx must be inverted
        logic [IDX_W-1:0] idx;
    } loc_stage_t;

    // Data bit i sits at the (i+1)-th position from 3 upward that is not a
    // power of two. Start at i+3 and step over each power of two reached.
    function automatic logic [POS_W-1:0] data_position(input int i);
        int pos;
        pos = i + 3;
        for (int k = 2; k < POS_W; k++) begin
            if (pos >= (1 << k)) begin
                pos = pos + 1;  // skip check bit slot
            end
        end
        return pos[POS_W-1:0];
    endfunction

    // low bits are the position, top bit set for an even popcount so every
    // column has an odd weight overall
    function automatic check_t check_column(input int i);
        logic [POS_W-1:0] pos;
        pos = data_position(i);
        return {~^pos, pos};
    endfunction

endpackage

//--- verilog/ecc87_encode_stage.sv
`timescale 1ns/1ns

module ecc87_encode_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_valid,
    input  ecc87_pkg::data_t      data_in,
    input  ecc87_pkg::check_t     parity_in,
    input  logic                  bypass,
    output ecc87_pkg::enc_stage_t enc
);

    ecc87_pkg::check_t calc_check;

    // each set data bit contributes its column
    always_comb begin
        calc_check = '0;
        for (int i = 0; i < ecc87_pkg::DATA_W; i++) begin
            if (data_in[i]) begin
                calc_check = calc_check ^ ecc87_pkg::check_column(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            enc.valid <= 1'b0;
        end else begin
            enc.valid <= in_valid;
        end
        enc.bypass     <= bypass;
        enc.data       <= data_in;
        enc.rx_check   <= parity_in;
        enc.calc_check <= calc_check;
    end

endmodule

//--- verilog/ecc87_locate_stage.sv
`timescale 1ns/1ns

module ecc87_locate_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  ecc87_pkg::enc_stage_t enc,
    output ecc87_pkg::loc_stage_t loc
);

    ecc87_pkg::check_t            syndrome;
    logic                         col_match;
    logic [ecc87_pkg::IDX_W-1:0]  match_idx;
    ecc87_pkg::err_kind_e         kind;
    logic                         flip;

    assign syndrome = enc.rx_check ^ enc.calc_check;

    // columns are unique, at most one hit
    always_comb begin
        col_match = 1'b0;
        match_idx = '0;
        for (int i = 0; i < ecc87_pkg::DATA_W; i++) begin
            if (syndrome == ecc87_pkg::check_column(i)) begin
                col_match = 1'b1;
                match_idx = ecc87_pkg::IDX_W'(i);
            end
        end
    end

    always_comb begin
        kind = ecc87_pkg::ERR_DOUBLE;
        flip = 1'b0;
        if (enc.bypass || syndrome == '0) begin
            kind = ecc87_pkg::ERR_NONE;
        end else if (col_match) begin
            kind = ecc87_pkg::ERR_SINGLE;  // data bit hit
            flip = 1'b1;
        end else if ($onehot(syndrome)) begin
            kind = ecc87_pkg::ERR_SINGLE;  // check bit hit, data intact
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            loc.valid <= 1'b0;
        end else begin
            loc.valid <= enc.valid;
        end
        loc.data       <= enc.data;
        loc.calc_check <= enc.calc_check;
        loc.kind       <= kind;
        loc.flip       <= flip;
        loc.idx        <= match_idx;
    end

    // a data flip is always a single error on an existing bit
    a_flip_in_range: assert property (@(posedge clk) disable iff (rst)
        loc.valid && loc.flip |-> loc.kind == ecc87_pkg::ERR_SINGLE
                                  && loc.idx < ecc87_pkg::DATA_W);

endmodule

//--- verilog/ecc87_correct_stage.sv
`timescale 1ns/1ns

module ecc87_correct_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  ecc87_pkg::loc_stage_t loc,
    output logic                  out_valid,
    output ecc87_pkg::data_t      data_out,
    output ecc87_pkg::check_t     parity_out,
    output logic                  sbit_err,
    output logic                  dbit_err
);

    ecc87_pkg::data_t corrected;

    always_comb begin
        corrected = loc.data;
        if (loc.flip) begin
            corrected[loc.idx] = ~loc.data[loc.idx];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            sbit_err  <= 1'b0;
            dbit_err  <= 1'b0;
        end else begin
            out_valid <= loc.valid;
            sbit_err  <= loc.valid && loc.kind == ecc87_pkg::ERR_SINGLE;
            dbit_err  <= loc.valid && loc.kind == ecc87_pkg::ERR_DOUBLE;
        end
        data_out   <= corrected;
        parity_out <= loc.calc_check;  // always the fresh check bits
    end

    a_flags_exclusive: assert property (@(posedge clk) disable iff (rst)
        !(sbit_err && dbit_err));

    a_idle_after_rst: assert property (@(posedge clk)
        rst |=> !out_valid);

endmodule

//--- verilog/ecc87_top.sv
`timescale 1ns/1ns

module ecc87_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              in_valid,
    input  ecc87_pkg::data_t  data_in,
    input  ecc87_pkg::check_t parity_in,
    input  logic              bypass,
    output logic              out_valid,
    output ecc87_pkg::data_t  data_out,
    output ecc87_pkg::check_t parity_out,
    output logic              sbit_err,
    output logic              dbit_err
);

    ecc87_pkg::enc_stage_t enc;
    ecc87_pkg::loc_stage_t loc;

    ecc87_encode_stage ecc87_encode_stage_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (in_valid),
        .data_in   (data_in),
        .parity_in (parity_in),
        .bypass    (bypass),
        .enc       (enc)
    );

    ecc87_locate_stage ecc87_locate_stage_inst (
        .clk (clk),
        .rst (rst),
        .enc (enc),
        .loc (loc)
    );

    ecc87_correct_stage ecc87_correct_stage_inst (
        .clk        (clk),
        .rst        (rst),
        .loc        (loc),
        .out_valid  (out_valid),
        .data_out   (data_out),
        .parity_out (parity_out),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

endmodule

//--- verif/ecc87_clkgen.sv
`timescale 1ns/1ns

module ecc87_clkgen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    // held for three rising edges
    initial begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

//--- verif/ecc87_tb.sv
`timescale 1ns/1ns

module ecc87_tb;

    typedef enum int {
        CASE_CLEAN,
        CASE_SINGLE_DATA,
        CASE_SINGLE_CHECK,
        CASE_DOUBLE,
        CASE_BYPASS
    } case_e;

    // one expected result per driven word
    typedef struct packed {
        ecc87_pkg::data_t  data;
        ecc87_pkg::check_t parity;
        logic              sbit;
        logic              dbit;
        logic [31:0]       cyc;   // cycle the word sat on the inputs
    } exp_t;

    logic              clk;
    logic              rst;
    logic              in_valid;
    ecc87_pkg::data_t  data_in;
    ecc87_pkg::check_t parity_in;
    logic              bypass;
    logic              out_valid;
    ecc87_pkg::data_t  data_out;
    ecc87_pkg::check_t parity_out;
    logic              sbit_err;
    logic              dbit_err;

    logic [ecc87_pkg::POS_W-1:0] pos_tab [ecc87_pkg::DATA_W];
    ecc87_pkg::check_t           col_tab [ecc87_pkg::DATA_W];

    exp_t exp_q[$];
    int   cyc = 0;
    int   sent = 0;
    int   received = 0;

    ecc87_clkgen ecc87_clkgen_inst (
        .clk (clk),
        .rst (rst)
    );

    ecc87_top ecc87_top_inst (
        .clk        (clk),
        .rst        (rst),
        .in_valid   (in_valid),
        .data_in    (data_in),
        .parity_in  (parity_in),
        .bypass     (bypass),
        .out_valid  (out_valid),
        .data_out   (data_out),
        .parity_out (parity_out),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "stopping at first error");
    endtask

    task automatic compare(input string name, input logic [127:0] actual,
                           input logic [127:0] expected);
        if (actual !== expected) begin
            fail_now($sformatf("Mismatch %s: actual %h expected %h", name, actual, expected));
        end
    endtask

    // walk the positions, skipping powers of two, to place each data bit
    task automatic build_tables();
        int n;
        n = 0;
        for (int p = 1; p < 128; p++) begin
            if (n < ecc87_pkg::DATA_W && (p & (p - 1)) != 0) begin
                pos_tab[n] = ecc87_pkg::POS_W'(p);
                n++;
            end
        end
        for (int i = 0; i < ecc87_pkg::DATA_W; i++) begin
            col_tab[i] = {($countones(pos_tab[i]) % 2 == 0), pos_tab[i]};
        end
    endtask

    function automatic ecc87_pkg::check_t model_check(input ecc87_pkg::data_t d);
        ecc87_pkg::check_t c;
        c = '0;
        for (int i = 0; i < ecc87_pkg::DATA_W; i++) begin
            for (int k = 0; k < ecc87_pkg::POS_W; k++) begin
                if (pos_tab[i][k]) begin
                    c[k] = c[k] ^ d[i];
                end
            end
            if ($countones(pos_tab[i]) % 2 == 0) begin
                c[7] = c[7] ^ d[i];  // overall parity bit
            end
        end
        return c;
    endfunction

    function automatic exp_t predict(input ecc87_pkg::data_t d, input ecc87_pkg::check_t p,
                                     input logic byp, input int word_cyc);
        exp_t              e;
        ecc87_pkg::check_t syn;
        logic              found;
        e.data   = d;
        e.parity = model_check(d);
        e.sbit   = 1'b0;
        e.dbit   = 1'b0;
        e.cyc    = 32'(word_cyc);
        syn      = p ^ e.parity;
        found    = 1'b0;
        if (!byp && syn != '0) begin
            for (int i = 0; i < ecc87_pkg::DATA_W; i++) begin
                if (syn == col_tab[i]) begin
                    e.data[i] = ~d[i];
                    found     = 1'b1;
                end
            end
            if (found || $countones(syn) == 1) begin
                e.sbit = 1'b1;
            end else begin
                e.dbit = 1'b1;
            end
        end
        return e;
    endfunction

    function automatic ecc87_pkg::data_t rand_data();
        logic [95:0] r;
        r = {$urandom(), $urandom(), $urandom()};
        return r[ecc87_pkg::DATA_W-1:0];
    endfunction

    // codeword is {check, data}, 95 bits
    task automatic make_case(input case_e kind, output ecc87_pkg::data_t d,
                             output ecc87_pkg::check_t p, output logic byp);
        logic [94:0] cw;
        int          j1;
        int          j2;
        int          nflip;
        d   = rand_data();
        p   = model_check(d);
        byp = 1'b0;
        cw  = {p, d};
        case (kind)
            CASE_SINGLE_DATA: begin
                j1 = int'($urandom_range(86, 0));
                cw[j1] = ~cw[j1];
            end
            CASE_SINGLE_CHECK: begin
                j1 = 87 + int'($urandom_range(7, 0));
                cw[j1] = ~cw[j1];
            end
            CASE_DOUBLE: begin
                j1 = int'($urandom_range(94, 0));
                j2 = (j1 + 1 + int'($urandom_range(93, 0))) % 95;  // never equals j1
                cw[j1] = ~cw[j1];
                cw[j2] = ~cw[j2];
            end
            CASE_BYPASS: begin
                byp   = 1'b1;
                nflip = int'($urandom_range(2, 0));
                for (int n = 0; n < nflip; n++) begin
                    j1 = int'($urandom_range(94, 0));
                    cw[j1] = ~cw[j1];
                end
            end
            default: begin
            end
        endcase
        d = cw[86:0];
        p = cw[94:87];
    endtask

    task automatic drive_word(input ecc87_pkg::data_t d, input ecc87_pkg::check_t p,
                              input logic byp);
        @(posedge clk);
        in_valid  <= 1'b1;
        data_in   <= d;
        parity_in <= p;
        bypass    <= byp;
        exp_q.push_back(predict(d, p, byp, cyc + 1));  // visible from the next negedge
        sent++;
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            in_valid <= 1'b0;
            bypass   <= 1'b0;
            data_in  <= rand_data();  // junk must not leak out
        end
    endtask

    task automatic run_section(input case_e kind, input int count);
        ecc87_pkg::data_t  d;
        ecc87_pkg::check_t p;
        logic              b;
        for (int n = 0; n < count; n++) begin
            make_case(kind, d, p, b);
            drive_word(d, p, b);
            idle(int'($urandom_range(2, 0)));
        end
    endtask

    task automatic run_burst(input int count);
        ecc87_pkg::data_t  d;
        ecc87_pkg::check_t p;
        logic              b;
        for (int n = 0; n < count; n++) begin
            make_case(case_e'($urandom_range(4, 0)), d, p, b);
            drive_word(d, p, b);
        end
        idle(1);
    endtask

    task automatic wait_reset_release();
        int n;
        n = 0;
        while (rst !== 1'b0 && n < 50) begin
            @(posedge clk);
            n++;
        end
        if (rst !== 1'b0) begin
            fail_now("reset was never released");
        end
    endtask

    task automatic drain_queue();
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < 50) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            fail_now($sformatf("%0d words never came out of the pipeline", exp_q.size()));
        end
    endtask

    task automatic check_idle(input int n);
        repeat (n) begin
            @(negedge clk);
            compare("out_valid", 128'(out_valid), 128'(0));
            compare("sbit_err", 128'(sbit_err), 128'(0));
            compare("dbit_err", 128'(dbit_err), 128'(0));
        end
    endtask

    task automatic check_outputs();
        exp_t e;
        if (out_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                fail_now("out_valid went high with no word in flight");
            end else begin
                e = exp_q.pop_front();
                received++;
                compare("arrival_cycle", 128'(cyc), 128'(e.cyc + 3));  // three stages
                compare("data_out", 128'(data_out), 128'(e.data));
                compare("parity_out", 128'(parity_out), 128'(e.parity));
                compare("sbit_err", 128'(sbit_err), 128'(e.sbit));
                compare("dbit_err", 128'(dbit_err), 128'(e.dbit));
            end
        end else begin
            compare("out_valid", 128'(out_valid), 128'(0));  // catches X
            compare("sbit_err", 128'(sbit_err), 128'(0));
            compare("dbit_err", 128'(dbit_err), 128'(0));
        end
    endtask

    // outputs settle well before the falling edge
    always @(negedge clk) begin
        cyc = cyc + 1;
        if (rst === 1'b0) begin
            check_outputs();
        end
    end

    initial begin
        repeat (20000) @(posedge clk);
        fail_now("simulation ran past its cycle limit");
    end

    initial begin
        in_valid  = 1'b0;
        data_in   = '0;
        parity_in = '0;
        bypass    = 1'b0;
        void'($urandom(32'hce60d590));
        build_tables();
        wait_reset_release();
        check_idle(6);
        run_section(CASE_CLEAN, 40);
        run_section(CASE_SINGLE_DATA, 40);
        run_section(CASE_SINGLE_CHECK, 24);
        run_section(CASE_DOUBLE, 40);
        run_section(CASE_BYPASS, 24);
        run_burst(200);  // in_valid held high throughout
        drain_queue();
        check_idle(4);
        if (received != sent) begin
            fail_now($sformatf("sent %0d words but received %0d", sent, received));
        end else begin
            $display("test passed");
            $finish;
        end
    end

endmodule

//--- build.f
verilog/ecc87_pkg.sv
verilog/ecc87_encode_stage.sv
verilog/ecc87_locate_stage.sv
verilog/ecc87_correct_stage.sv
verilog/ecc87_top.sv
verif/ecc87_clkgen.sv
verif/ecc87_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the ecc87 testbench with Verilator

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert --top-module ecc87_tb -f build.f -o ecc87_sim \
    && ./obj_dir/ecc87_sim > "$LOG" 2>&1 \
    || echo "build or simulation exited with an error"

cat "$LOG" 2>/dev/null

grep -q "test failed" "$LOG" && { echo "FAIL"; exit 1; }
grep -q "test passed" "$LOG" || { echo "FAIL: no pass line in $LOG"; exit 1; }
echo "PASS"
exit 0
